// File: vlog.f
+incdir+verilog
verilog/filter_cfg_pkg.sv
verilog/setup_packet_filter.sv
verilog/sync_fifo.sv
verilog/cfg_word_assembler.sv
verilog/filter_cfg_loader.sv
tb/tb_clock_gen.sv
tb/filter_cfg_loader_tb.sv

// File: Bender.yml
package:
  name: filter_cfg_loader

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/filter_cfg_pkg.sv
      - verilog/setup_packet_filter.sv
      - verilog/sync_fifo.sv
      - verilog/cfg_word_assembler.sv
      - verilog/filter_cfg_loader.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clock_gen.sv
      - tb/filter_cfg_loader_tb.sv

// File: tb/filter_cfg_loader_tb.sv
// Filter-condition loader testbench
// Directed tests for reset, decode, filtering, shifted offsets and back-pressure

`default_nettype none

module filter_cfg_loader_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_words      = 9;
    localparam int record_timeout = 2000;

    logic                             ap_clk;
    logic                             arst_n;
    filter_cfg_pkg::mem_resp_t        resp_in;
    logic                             resp_drain_en;
    logic                             cfg_rd_en;
    filter_cfg_pkg::cfg_out_t         cfg_out;
    logic                             resp_fifo_full;
    logic                             cfg_fifo_full;

    // Data words of the group being sent, and records still to come
    logic [31:0]                      group_words [num_words];
    filter_cfg_pkg::filter_cond_cfg_t exp_q [$];

    tb_clock_gen tb_clock_gen_inst (
        .ap_clk(ap_clk),
        .arst_n(arst_n)
    );

    filter_cfg_loader #(
        .seq_base(0)
    ) filter_cfg_loader_inst (
        .ap_clk        (ap_clk),
        .arst_n        (arst_n),
        .resp_in       (resp_in),
        .resp_drain_en (resp_drain_en),
        .cfg_rd_en     (cfg_rd_en),
        .cfg_out       (cfg_out),
        .resp_fifo_full(resp_fifo_full),
        .cfg_fifo_full (cfg_fifo_full)
    );

    // ----------------------------------------
    // Checking helpers
    // ----------------------------------------
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Record as the decode table defines it, straight from the word bits
    function automatic filter_cfg_pkg::filter_cond_cfg_t build_expected();
        filter_cfg_pkg::filter_cond_cfg_t rec;
        rec.filter_op            = filter_cfg_pkg::filter_op_e'(group_words[0][3:0]);
        rec.filter_mask          = group_words[1][3:0];
        rec.const_mask           = group_words[2][3:0];
        rec.const_value          = group_words[3];
        rec.ops_mask             = group_words[4][15:0];
        rec.break_flag           = group_words[5][0];
        rec.break_pass           = group_words[5][1];
        rec.filter_post          = group_words[5][2];
        rec.filter_pass          = group_words[5][3];
        rec.continue_flag        = group_words[5][4];
        rec.ternary_flag         = group_words[5][5];
        rec.conditional_flag     = group_words[5][6];
        rec.route_if.id_cu       = group_words[6][1:0];
        rec.route_if.id_bundle   = group_words[6][3:2];
        rec.route_if.id_lane     = group_words[6][6:4];
        rec.route_if.id_buffer   = group_words[6][9:7];
        rec.route_else.id_cu     = group_words[7][1:0];
        rec.route_else.id_bundle = group_words[7][3:2];
        rec.route_else.id_lane   = group_words[7][6:4];
        rec.route_else.id_buffer = group_words[7][9:7];
        rec.route_if.id_engine   = group_words[8][2:0];
        rec.route_if.id_module   = group_words[8][4:3];
        rec.route_else.id_engine = group_words[8][7:5];
        rec.route_else.id_module = group_words[8][9:8];
        return rec;
    endfunction

    task automatic compare_record(input filter_cfg_pkg::filter_cond_cfg_t act,
                                  input filter_cfg_pkg::filter_cond_cfg_t exp_rec);
        check_value("cfg_out.cfg.filter_op", act.filter_op, exp_rec.filter_op);
        check_value("cfg_out.cfg.filter_mask", act.filter_mask, exp_rec.filter_mask);
        check_value("cfg_out.cfg.const_mask", act.const_mask, exp_rec.const_mask);
        check_value("cfg_out.cfg.const_value", act.const_value, exp_rec.const_value);
        check_value("cfg_out.cfg.ops_mask", act.ops_mask, exp_rec.ops_mask);
        check_value("cfg_out.cfg flags",
            {act.conditional_flag, act.ternary_flag, act.continue_flag, act.filter_pass,
             act.filter_post, act.break_pass, act.break_flag},
            {exp_rec.conditional_flag, exp_rec.ternary_flag, exp_rec.continue_flag,
             exp_rec.filter_pass, exp_rec.filter_post, exp_rec.break_pass,
             exp_rec.break_flag});
        check_value("cfg_out.cfg.route_if", act.route_if, exp_rec.route_if);
        check_value("cfg_out.cfg.route_else", act.route_else, exp_rec.route_else);
    endtask

    // Outputs are sampled on the falling edge
    task automatic wait_record(output filter_cfg_pkg::filter_cond_cfg_t rec);
        int  cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < record_timeout) begin
            @(negedge ap_clk);
            cycles++;
            if (cfg_out.valid === 1'b1) begin
                rec  = cfg_out.cfg;
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("Timeout: no record appeared on cfg_out within %0d cycles",
                     record_timeout);
            $display("Test FAILED");
            $fatal(1, "record timeout");
        end
    endtask

    task automatic receive_and_compare();
        filter_cfg_pkg::filter_cond_cfg_t act;
        filter_cfg_pkg::filter_cond_cfg_t exp_rec;
        wait_record(act);
        if (exp_q.size() == 0) begin
            $display("A record arrived on cfg_out although none was expected");
            $display("Test FAILED");
            $fatal(1, "unexpected record");
        end else begin
            exp_rec = exp_q.pop_front();
            compare_record(act, exp_rec);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge ap_clk);
            check_value("cfg_out.valid", cfg_out.valid, 1'b0);
        end
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic set_enables(input logic drain, input logic rd);
        @(negedge ap_clk);
        resp_drain_en = drain;
        cfg_rd_en     = rd;
    endtask

    task automatic send_word(input filter_cfg_pkg::buffer_kind_e kind,
                             input logic [15:0] offset, input logic [3:0] shift,
                             input logic [31:0] data);
        @(negedge ap_clk);
        resp_in.valid          = 1'b1;
        resp_in.payload.kind   = kind;
        resp_in.payload.offset = offset;
        resp_in.payload.shift  = shift;
        resp_in.payload.data   = data;
    endtask

    task automatic input_idle();
        @(negedge ap_clk);
        resp_in.valid = 1'b0;
    endtask

    task automatic fill_random_group();
        for (int i = 0; i < num_words; i++) begin
            group_words[i] = $urandom();
        end
        exp_q.push_back(build_expected());
    endtask

    // Offsets are the sequence number scaled up by the shift
    task automatic send_group(input filter_cfg_pkg::buffer_kind_e kind,
                              input logic [3:0] shift);
        logic [15:0] offset;
        for (int i = 0; i < num_words; i++) begin
            offset = 16'(i) << shift;
            send_word(kind, offset, shift, group_words[i]);
        end
        input_idle();
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset();
        int cycles;
        cycles = 0;
        // Skip time zero, where the clock first leaves X
        @(posedge ap_clk);
        while (arst_n !== 1'b1 && cycles < 100) begin
            @(negedge ap_clk);
            check_value("cfg_out.valid", cfg_out.valid, 1'b0);
            check_value("resp_fifo_full", resp_fifo_full, 1'b0);
            check_value("cfg_fifo_full", cfg_fifo_full, 1'b0);
            if (arst_n !== 1'b1) begin
                cycles++;
            end
        end
        if (cycles >= 100) begin
            $display("Timeout: reset was never released");
            $display("Test FAILED");
            $fatal(1, "reset timeout");
        end else begin
            check_value("reset cycles", cycles, 16);
            expect_quiet(10);
            check_value("resp_fifo_full", resp_fifo_full, 1'b0);
            check_value("cfg_fifo_full", cfg_fifo_full, 1'b0);
        end
    endtask

    task automatic test_full_decode();
        set_enables(1'b1, 1'b1);
        fill_random_group();
        send_group(filter_cfg_pkg::STRUCT_CU_SETUP, 4'd0);
        receive_and_compare();
        // Exactly one record per group
        expect_quiet(50);
    endtask

    task automatic test_filtering();
        // Wrong kind, then a stray middle word while idle
        for (int i = 0; i < num_words; i++) begin
            send_word(filter_cfg_pkg::STRUCT_OTHER, 16'(i), 4'd0, $urandom());
        end
        send_word(filter_cfg_pkg::STRUCT_ENGINE_SETUP, 16'd3, 4'd0, $urandom());
        input_idle();
        expect_quiet(60);
        // Out-of-window words between the words of a valid group
        fill_random_group();
        for (int i = 0; i < num_words; i++) begin
            send_word(filter_cfg_pkg::STRUCT_ENGINE_SETUP, 16'(i), 4'd0, group_words[i]);
            send_word(filter_cfg_pkg::STRUCT_CU_SETUP, 16'(num_words + i), 4'd0,
                      $urandom());
        end
        input_idle();
        receive_and_compare();
        expect_quiet(30);
    endtask

    task automatic test_shift();
        fill_random_group();
        send_group(filter_cfg_pkg::STRUCT_CU_SETUP, 4'd0);
        receive_and_compare();
        exp_q.push_back(build_expected());
        send_group(filter_cfg_pkg::STRUCT_ENGINE_SETUP, 4'd2);
        receive_and_compare();
        expect_quiet(30);
    endtask

    task automatic test_rd_backpressure();
        set_enables(1'b1, 1'b0);
        fill_random_group();
        send_group(filter_cfg_pkg::STRUCT_CU_SETUP, 4'd0);
        fill_random_group();
        send_group(filter_cfg_pkg::STRUCT_ENGINE_SETUP, 4'd0);
        expect_quiet(80);
        check_value("cfg_fifo_full", cfg_fifo_full, 1'b0);
        set_enables(1'b1, 1'b1);
        receive_and_compare();
        receive_and_compare();
        expect_quiet(30);
    endtask

    task automatic test_drain_backpressure();
        set_enables(1'b0, 1'b1);
        fill_random_group();
        send_group(filter_cfg_pkg::STRUCT_CU_SETUP, 4'd0);
        expect_quiet(60);
        check_value("resp_fifo_full", resp_fifo_full, 1'b0);
        set_enables(1'b1, 1'b1);
        receive_and_compare();
        expect_quiet(30);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        resp_in       = '0;
        resp_drain_en = 1'b0;
        cfg_rd_en     = 1'b0;
        void'($urandom(32'hd406_f2d7));

        test_reset();
        test_full_decode();
        test_filtering();
        test_shift();
        test_rd_backpressure();
        test_drain_backpressure();

        if (exp_q.size() != 0) begin
            $display("%0d expected records never arrived on cfg_out", exp_q.size());
            $display("Test FAILED");
            $fatal(1, "records missing");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// Testbench clock and reset source
// 100 ns clock, reset held low for the first 16 cycles

`default_nettype none

module tb_clock_gen (
    output logic ap_clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // Release on a falling edge, clear of the DUT's rising edge
    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge ap_clk);
        @(negedge ap_clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/filter_cfg_loader.sv
// Filter-condition configuration loader
// Filters setup responses, queues them, assembles records and buffers the output

`default_nettype none

`include "filter_cfg_params.svh"

module filter_cfg_loader #(
    parameter int unsigned seq_base = 0
) (
    input  wire                            ap_clk,
    input  wire                            arst_n,
    input  wire filter_cfg_pkg::mem_resp_t resp_in,
    input  wire                            resp_drain_en,
    input  wire                            cfg_rd_en,
    output filter_cfg_pkg::cfg_out_t       cfg_out,
    output logic                           resp_fifo_full,
    output logic                           cfg_fifo_full
);

    localparam int resp_w = $bits(filter_cfg_pkg::mem_resp_payload_t);
    localparam int cfg_w  = $bits(filter_cfg_pkg::filter_cond_cfg_t);

    logic                              drain_en_q;
    logic                              rd_en_q;

    logic                              in_push;
    filter_cfg_pkg::mem_resp_payload_t in_din;
    logic                              in_pop;
    filter_cfg_pkg::mem_resp_payload_t in_dout;
    logic                              in_valid;
    logic                              in_empty;

    logic                              out_push;
    filter_cfg_pkg::filter_cond_cfg_t  out_din;
    logic                              out_pop;
    filter_cfg_pkg::filter_cond_cfg_t  out_dout;
    logic                              out_valid;
    logic                              out_empty;
    logic                              out_prog_full;

    logic                              cfg_vld_q;
    filter_cfg_pkg::filter_cond_cfg_t  cfg_q;

    // ----------------------------------------
    // External enables and output register
    // ----------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            drain_en_q <= 1'b0;
            rd_en_q    <= 1'b0;
            cfg_vld_q  <= 1'b0;
        end else begin
            drain_en_q <= resp_drain_en;
            rd_en_q    <= cfg_rd_en;
            cfg_vld_q  <= out_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        cfg_q <= out_dout;
    end

    assign cfg_out.valid = cfg_vld_q;
    assign cfg_out.cfg   = cfg_q;

    // ----------------------------------------
    // Stage 1 and input FIFO
    // ----------------------------------------
    setup_packet_filter #(
        .seq_base(seq_base)
    ) setup_packet_filter_inst (
        .ap_clk   (ap_clk),
        .arst_n   (arst_n),
        .resp_in  (resp_in),
        .push     (in_push),
        .push_data(in_din)
    );

    sync_fifo #(
        .width      (resp_w),
        .depth      (`FCFG_FIFO_DEPTH),
        .prog_thresh(`FCFG_PROG_THRESH)
    ) resp_fifo_inst (
        .ap_clk   (ap_clk),
        .arst_n   (arst_n),
        .din      (in_din),
        .wr_en    (in_push),
        .rd_en    (in_pop),
        .dout     (in_dout),
        .valid    (in_valid),
        .full     (resp_fifo_full),
        .empty    (in_empty),
        .prog_full()
    );

    // ----------------------------------------
    // Stage 2 and output FIFO
    // ----------------------------------------
    cfg_word_assembler #(
        .seq_base(seq_base)
    ) cfg_word_assembler_inst (
        .ap_clk       (ap_clk),
        .arst_n       (arst_n),
        .drain_en     (drain_en_q),
        .in_empty     (in_empty),
        .out_prog_full(out_prog_full),
        .pop          (in_pop),
        .in_data      (in_dout),
        .in_valid     (in_valid),
        .cfg_push     (out_push),
        .cfg_data     (out_din)
    );

    assign out_pop = ~out_empty & rd_en_q;

    sync_fifo #(
        .width      (cfg_w),
        .depth      (`FCFG_FIFO_DEPTH),
        .prog_thresh(`FCFG_PROG_THRESH)
    ) cfg_fifo_inst (
        .ap_clk   (ap_clk),
        .arst_n   (arst_n),
        .din      (out_din),
        .wr_en    (out_push),
        .rd_en    (out_pop),
        .dout     (out_dout),
        .valid    (out_valid),
        .full     (cfg_fifo_full),
        .empty    (out_empty),
        .prog_full(out_prog_full)
    );

endmodule

`default_nettype wire

// File: verilog/cfg_word_assembler.sv
// Configuration word assembler
// Pops queued setup words and decodes them in order into one filter record

`default_nettype none

`include "filter_cfg_params.svh"

module cfg_word_assembler #(
    parameter int unsigned seq_base = 0
) (
    input  wire                                   ap_clk,
    input  wire                                   arst_n,
    input  wire                                   drain_en,
    input  wire                                   in_empty,
    input  wire                                   out_prog_full,
    output logic                                  pop,
    input  wire filter_cfg_pkg::mem_resp_payload_t in_data,
    input  wire                                   in_valid,
    output logic                                  cfg_push,
    output filter_cfg_pkg::filter_cond_cfg_t      cfg_data
);

    localparam int                        last_bit  = `FCFG_WORD_COUNT - 1;
    localparam logic [`FCFG_OFFSET_W-1:0] seq_first = `FCFG_OFFSET_W'(seq_base);

    logic [`FCFG_WORD_COUNT-1:0]       seq_reg;
    logic [`FCFG_OFFSET_W-1:0]         in_seq;
    logic                              idle;
    logic                              start;
    logic                              emit;
    logic                              word_vld;
    filter_cfg_pkg::mem_resp_payload_t word_q;
    filter_cfg_pkg::cfg_word_u         word_u;
    filter_cfg_pkg::filter_cond_cfg_t  rec;

    // ----------------------------------------
    // Pop request
    // ----------------------------------------
    // Hold off while a record is emitted or the output side backs up
    assign pop = ~in_empty & drain_en & ~emit & ~out_prog_full;

    // ----------------------------------------
    // One-hot sequencer
    // ----------------------------------------
    assign in_seq = in_data.offset >> in_data.shift;

    // The last-word bit drops out next cycle, so a new record may start on it
    assign idle  = ~|seq_reg[last_bit-1:0];
    assign start = in_valid & idle & (in_seq == seq_first);

    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            seq_reg  <= '0;
            word_vld <= 1'b0;
            emit     <= 1'b0;
            cfg_push <= 1'b0;
        end else begin
            word_vld <= in_valid;
            emit     <= seq_reg[last_bit];
            cfg_push <= emit;
            if (start) begin
                seq_reg <= `FCFG_WORD_COUNT'(1);
            end else if (in_valid || seq_reg[last_bit]) begin
                // A stray word while idle shifts zero and is dropped
                seq_reg <= seq_reg << 1;
            end
        end
    end

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        word_q <= in_data;
    end

    assign word_u = filter_cfg_pkg::cfg_word_u'(word_q.data);

    // Register bit selects which field the held word carries
    always_ff @(posedge ap_clk) begin
        if (word_vld) begin
            case (1'b1)
                seq_reg[0]: begin
                    rec.filter_op <= filter_cfg_pkg::filter_op_e'(word_u.raw[`FCFG_OP_W-1:0]);
                end
                seq_reg[1]: begin
                    rec.filter_mask <= word_u.raw[`FCFG_NUM_FIELDS-1:0];
                end
                seq_reg[2]: begin
                    rec.const_mask <= word_u.raw[`FCFG_NUM_FIELDS-1:0];
                end
                seq_reg[3]: begin
                    rec.const_value <= word_u.raw;
                end
                seq_reg[4]: begin
                    rec.ops_mask <= word_u.raw[`FCFG_NUM_FIELDS*`FCFG_NUM_FIELDS-1:0];
                end
                seq_reg[5]: begin
                    rec.break_flag       <= word_u.flags_view.break_flag;
                    rec.break_pass       <= word_u.flags_view.break_pass;
                    rec.filter_post      <= word_u.flags_view.filter_post;
                    rec.filter_pass      <= word_u.flags_view.filter_pass;
                    rec.continue_flag    <= word_u.flags_view.continue_flag;
                    rec.ternary_flag     <= word_u.flags_view.ternary_flag;
                    rec.conditional_flag <= word_u.flags_view.conditional_flag;
                end
                seq_reg[6]: begin
                    rec.route_if.id_cu     <= word_u.route_view.cu;
                    rec.route_if.id_bundle <= word_u.route_view.bundle;
                    rec.route_if.id_lane   <= word_u.route_view.lane;
                    rec.route_if.id_buffer <= word_u.route_view.buffer;
                end
                seq_reg[7]: begin
                    rec.route_else.id_cu     <= word_u.route_view.cu;
                    rec.route_else.id_bundle <= word_u.route_view.bundle;
                    rec.route_else.id_lane   <= word_u.route_view.lane;
                    rec.route_else.id_buffer <= word_u.route_view.buffer;
                end
                seq_reg[8]: begin
                    rec.route_if.id_engine   <= word_u.engine_view.if_engine;
                    rec.route_if.id_module   <= word_u.engine_view.if_module;
                    rec.route_else.id_engine <= word_u.engine_view.else_engine;
                    rec.route_else.id_module <= word_u.engine_view.else_module;
                end
                default: begin
                    rec <= rec;
                end
            endcase
        end
    end

    // Snapshot on emit, so a following record may already start decoding
    always_ff @(posedge ap_clk) begin
        if (emit) begin
            cfg_data <= rec;
        end
    end

    a_seq_onehot: assert property (@(posedge ap_clk) disable iff (!arst_n)
        $onehot0(seq_reg))
        else $error("cfg_word_assembler: sequencer not one-hot");

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
// Synchronous FIFO
// Registered read data with a valid strobe, plus full, empty and programmable-full

`default_nettype none

module sync_fifo #(
    parameter int width       = 8,
    parameter int depth       = 16,
    parameter int prog_thresh = 8
) (
    input  wire              ap_clk,
    input  wire              arst_n,
    input  wire [width-1:0]  din,
    input  wire              wr_en,
    input  wire              rd_en,
    output logic [width-1:0] dout,
    output logic             valid,
    output logic             full,
    output logic             empty,
    output logic             prog_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
        ptr_next = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == cnt_w'(depth));
    assign empty     = (count == '0);
    assign prog_full = (count >= cnt_w'(prog_thresh));

    // Writes into a full FIFO are dropped
    assign wr_ok = wr_en & ~full;
    assign rd_ok = rd_en & ~empty;

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    // ----------------------------------------
    // Checks on the callers' flow control
    // ----------------------------------------
    a_no_write_full: assert property (@(posedge ap_clk) disable iff (!arst_n)
        wr_en |-> !full)
        else $error("sync_fifo: write while full");

    a_no_pop_empty: assert property (@(posedge ap_clk) disable iff (!arst_n)
        rd_en |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

// File: verilog/setup_packet_filter.sv
// Setup packet filter
// Registers memory responses and keeps setup words inside this engine's window

`default_nettype none

`include "filter_cfg_params.svh"

module setup_packet_filter #(
    parameter int unsigned seq_base = 0
) (
    input  wire                                ap_clk,
    input  wire                                arst_n,
    input  wire filter_cfg_pkg::mem_resp_t     resp_in,
    output logic                               push,
    output filter_cfg_pkg::mem_resp_payload_t  push_data
);

    localparam logic [`FCFG_OFFSET_W-1:0] seq_lo = `FCFG_OFFSET_W'(seq_base);
    localparam logic [`FCFG_OFFSET_W-1:0] seq_hi = `FCFG_OFFSET_W'(seq_base + `FCFG_WORD_COUNT);

    logic                              resp_vld_q;
    filter_cfg_pkg::mem_resp_payload_t resp_q;
    logic [`FCFG_OFFSET_W-1:0]         resp_seq;
    logic                              kind_ok;
    logic                              seq_ok;

    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_vld_q <= 1'b0;
        end else begin
            resp_vld_q <= resp_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_q <= resp_in.payload;
    end

    // Sequence number of the word within the setup buffer
    assign resp_seq = resp_q.offset >> resp_q.shift;

    assign kind_ok = (resp_q.kind == filter_cfg_pkg::STRUCT_CU_SETUP) ||
                     (resp_q.kind == filter_cfg_pkg::STRUCT_ENGINE_SETUP);
    assign seq_ok  = (resp_seq >= seq_lo) && (resp_seq < seq_hi);

    assign push      = resp_vld_q & kind_ok & seq_ok;
    assign push_data = resp_q;

endmodule

`default_nettype wire

// File: verilog/filter_cfg_pkg.sv
// Filter-condition loader types
// Response words, the decoded filter record and the views of a config word

`default_nettype none

`include "filter_cfg_params.svh"

package filter_cfg_pkg;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [2:0] {
        STRUCT_INVALID      = 3'd0,
        STRUCT_CU_SETUP     = 3'd1,
        STRUCT_ENGINE_SETUP = 3'd2,
        STRUCT_OTHER        = 3'd3
    } buffer_kind_e;

    // Codes not listed here are still carried through
    typedef enum logic [`FCFG_OP_W-1:0] {
        FILTER_NOP = 4'd0,
        FILTER_GT  = 4'd1,
        FILTER_LT  = 4'd2,
        FILTER_EQ  = 4'd3,
        FILTER_NE  = 4'd4,
        FILTER_GE  = 4'd5,
        FILTER_LE  = 4'd6,
        FILTER_AND = 4'd7,
        FILTER_OR  = 4'd8
    } filter_op_e;

    // ----------------------------------------
    // Memory response stream
    // ----------------------------------------
    typedef struct packed {
        buffer_kind_e              kind;
        logic [`FCFG_OFFSET_W-1:0] offset;
        logic [`FCFG_SHIFT_W-1:0]  shift;
        logic [`FCFG_DATA_W-1:0]   data;
    } mem_resp_payload_t;

    typedef struct packed {
        logic              valid;
        mem_resp_payload_t payload;
    } mem_resp_t;

    // ----------------------------------------
    // Decoded record
    // ----------------------------------------
    typedef struct packed {
        logic [`FCFG_KERNEL_W-1:0] id_cu;
        logic [`FCFG_BUNDLE_W-1:0] id_bundle;
        logic [`FCFG_LANE_W-1:0]   id_lane;
        logic [`FCFG_BUFFER_W-1:0] id_buffer;
        logic [`FCFG_ENGINE_W-1:0] id_engine;
        logic [`FCFG_MODULE_W-1:0] id_module;
    } filter_route_t;

    typedef struct packed {
        filter_op_e                                   filter_op;
        logic [`FCFG_NUM_FIELDS-1:0]                  filter_mask;
        logic [`FCFG_NUM_FIELDS-1:0]                  const_mask;
        logic [`FCFG_DATA_W-1:0]                      const_value;
        logic [`FCFG_NUM_FIELDS*`FCFG_NUM_FIELDS-1:0] ops_mask;
        logic                                         break_flag;
        logic                                         break_pass;
        logic                                         filter_post;
        logic                                         filter_pass;
        logic                                         continue_flag;
        logic                                         ternary_flag;
        logic                                         conditional_flag;
        filter_route_t                                route_if;
        filter_route_t                                route_else;
    } filter_cond_cfg_t;

    typedef struct packed {
        logic             valid;
        filter_cond_cfg_t cfg;
    } cfg_out_t;

    // ----------------------------------------
    // Config data word, read by position
    // ----------------------------------------
    // Flags sit in bits 0 to 6, break_flag lowest
    typedef struct packed {
        logic [`FCFG_DATA_W-8:0] rsvd;
        logic                    conditional_flag;
        logic                    ternary_flag;
        logic                    continue_flag;
        logic                    filter_pass;
        logic                    filter_post;
        logic                    break_pass;
        logic                    break_flag;
    } flags_view_t;

    typedef struct packed {
        logic [`FCFG_DATA_W-`FCFG_KERNEL_W-`FCFG_BUNDLE_W-`FCFG_LANE_W-`FCFG_BUFFER_W-1:0] rsvd;
        logic [`FCFG_BUFFER_W-1:0]                                                     buffer;
        logic [`FCFG_LANE_W-1:0]                                                       lane;
        logic [`FCFG_BUNDLE_W-1:0]                                                     bundle;
        logic [`FCFG_KERNEL_W-1:0]                                                     cu;
    } route_view_t;

    typedef struct packed {
        logic [`FCFG_DATA_W-2*(`FCFG_ENGINE_W+`FCFG_MODULE_W)-1:0] rsvd;
        logic [`FCFG_MODULE_W-1:0]                               else_module;
        logic [`FCFG_ENGINE_W-1:0]                               else_engine;
        logic [`FCFG_MODULE_W-1:0]                               if_module;
        logic [`FCFG_ENGINE_W-1:0]                               if_engine;
    } engine_view_t;

    typedef union packed {
        logic [`FCFG_DATA_W-1:0] raw;
        flags_view_t             flags_view;
        route_view_t             route_view;
        engine_view_t            engine_view;
    } cfg_word_u;

endpackage

`default_nettype wire

// File: verilog/filter_cfg_params.svh
// Filter-condition loader parameters
// Data and address widths, FIFO sizing, record word count and route id widths

`ifndef FILTER_CFG_PARAMS_SVH
`define FILTER_CFG_PARAMS_SVH

// Memory response word
`define FCFG_DATA_W       32
`define FCFG_OFFSET_W     16
`define FCFG_SHIFT_W      4

// Filter record fields
`define FCFG_NUM_FIELDS   4
`define FCFG_OP_W         4

// Words per record, also the width of the sequence window
`define FCFG_WORD_COUNT   9

// Both FIFOs
`define FCFG_FIFO_DEPTH   16
`define FCFG_PROG_THRESH  8

// Route id widths
`define FCFG_KERNEL_W     2
`define FCFG_BUNDLE_W     2
`define FCFG_LANE_W       3
`define FCFG_BUFFER_W     3
`define FCFG_ENGINE_W     3
`define FCFG_MODULE_W     2

`endif
